// File: source/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizing
////////////////////////////////////////////////////////////////////////////

// Data path and bus address width
`define PIPE_XLEN 32

// Architectural registers, r0 reads as zero
`define PIPE_NREG 16

// Immediate field, sign-extended to PIPE_XLEN
`define PIPE_IMMW 12

`endif

// File: source/pipe_pkg.sv
`include "pipe_defines.svh"

package pipe_pkg;

  localparam int unsigned RF_AW = $clog2(`PIPE_NREG); // Register address bits

  typedef logic [RF_AW-1:0] rf_addr_t;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_ADDI = 4'd5,
    OP_LW   = 4'd6,                                    // rd <= mem[rs1 + imm]
    OP_SW   = 4'd7                                     // mem[rs1 + imm] <= rd field reg
  } opcode_e;

  // Register-register view
  typedef struct packed {
    opcode_e                        opcode;
    rf_addr_t                       rd;
    rf_addr_t                       rs1;
    rf_addr_t                       rs2;
    logic [`PIPE_XLEN-4-3*RF_AW-1:0] unused;
  } insn_rr_t;

  // Register-immediate view, SW keeps its data register in rd
  typedef struct packed {
    opcode_e                                   opcode;
    rf_addr_t                                  rd;
    rf_addr_t                                  rs1;
    logic [`PIPE_IMMW-1:0]                     imm;
    logic [`PIPE_XLEN-4-2*RF_AW-`PIPE_IMMW-1:0] unused;
  } insn_ri_t;

  typedef union packed {
    insn_rr_t rr;
    insn_ri_t ri;
  } insn_u;

  // Operand source for the decode forward muxes
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } op_fw_mux_e;

  typedef struct packed {
    logic                  valid;
    opcode_e               opcode;
    rf_addr_t              rd;
    logic                  we;                         // Cleared for bubbles and r0
    logic                  data_req;                   // Load or store
    logic                  data_we;                    // Store
    logic [`PIPE_XLEN-1:0] operand_a;
    logic [`PIPE_XLEN-1:0] operand_b;                  // Already holds imm where used
    logic [`PIPE_XLEN-1:0] store_data;
  } id_ex_pipe_t;

  typedef struct packed {
    logic                  valid;
    rf_addr_t              rd;
    logic                  we;
    logic                  data_req;
    logic                  data_we;
    logic [`PIPE_XLEN-1:0] result;                     // ALU result or bus address
    logic [`PIPE_XLEN-1:0] store_data;
  } ex_wb_pipe_t;

endpackage

// File: source/hazard_if.sv
`timescale 1ns/1ps

interface hazard_if import pipe_pkg::*; ();

  // ID side
  logic [1:0] rf_re;                                   // Per read port enable
  rf_addr_t   rf_raddr [2];
  rf_addr_t   rf_waddr;                                // Destination of the ID instruction

  // EX side
  logic       rf_we_ex;
  rf_addr_t   rf_waddr_ex;
  logic       data_req_ex;                             // Load or store sits in EX

  // WB side
  logic       rf_we_wb;
  rf_addr_t   rf_waddr_wb;
  logic       data_req_wb;
  logic       wb_ready;                                // Low while the bus access is open

  modport decode    (output rf_re, rf_raddr, rf_waddr, input wb_ready);
  modport execute   (output rf_we_ex, rf_waddr_ex, data_req_ex);
  modport writeback (output rf_we_wb, rf_waddr_wb, data_req_wb, wb_ready);
  modport ctrl      (input rf_re, rf_raddr, rf_waddr, rf_we_ex, rf_waddr_ex, data_req_ex,
                     input rf_we_wb, rf_waddr_wb, data_req_wb, wb_ready);

endinterface

// File: source/regfile.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module regfile import pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  rf_addr_t              raddr_a_i,
  input  rf_addr_t              raddr_b_i,
  output logic [`PIPE_XLEN-1:0] rdata_a_o,
  output logic [`PIPE_XLEN-1:0] rdata_b_o,
  input  logic                  we_i,
  input  rf_addr_t              waddr_i,
  input  logic [`PIPE_XLEN-1:0] wdata_i
);

  logic [`PIPE_XLEN-1:0] regs_q [`PIPE_NREG];

  // Whole array clears on reset, r0 is never written after that
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `PIPE_NREG; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
      regs_q[waddr_i] <= wdata_i;
  end

  assign rdata_a_o = regs_q[raddr_a_i];                // Same-cycle write is covered by WB fwd
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module decode_stage import pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  insn_u                 instr_i,
  output logic                  instr_ready_o,
  hazard_if.decode              hz,
  input  op_fw_mux_e            operand_a_sel_i,
  input  op_fw_mux_e            operand_b_sel_i,
  input  logic                  stall_i,              // Load-use or bus wait
  input  logic                  deassert_we_i,
  input  logic [`PIPE_XLEN-1:0] fw_ex_data_i,
  input  logic [`PIPE_XLEN-1:0] fw_wb_data_i,
  input  logic                  rf_we_i,
  input  rf_addr_t              rf_waddr_i,
  input  logic [`PIPE_XLEN-1:0] rf_wdata_i,
  output id_ex_pipe_t           id_ex_o
);

  opcode_e               opcode;
  logic                  use_imm, we_dec, data_req_dec, data_we_dec;
  logic                  ready_q, accept;
  logic [`PIPE_XLEN-1:0] imm_ext, rdata_a, rdata_b, op_a_fw, op_b_fw;

  function automatic logic [`PIPE_XLEN-1:0] fw_mux(input op_fw_mux_e sel,
      input logic [`PIPE_XLEN-1:0] rf_val, ex_val, wb_val);
    case (sel)
      SEL_FW_EX: return ex_val;
      SEL_FW_WB: return wb_val;
      default:   return rf_val;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Instruction decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = instr_i.rr.opcode;                   // Opcode sits in the same bits in both views

  always_comb
  begin
    hz.rf_re     = 2'b00;
    use_imm      = 1'b0;
    we_dec       = 1'b0;
    data_req_dec = 1'b0;
    data_we_dec  = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR:
      begin
        hz.rf_re = 2'b11;
        we_dec   = 1'b1;
      end
      OP_ADDI, OP_LW:
      begin
        hz.rf_re     = 2'b01;                          // Base only
        use_imm      = 1'b1;
        we_dec       = 1'b1;
        data_req_dec = (opcode == OP_LW);
      end
      OP_SW:
      begin
        hz.rf_re     = 2'b11;                          // Base and store data
        use_imm      = 1'b1;
        data_req_dec = 1'b1;
        data_we_dec  = 1'b1;
      end
      default: ;                                       // NOP and unused codes
    endcase
  end

  assign hz.rf_raddr[0] = instr_i.rr.rs1;
  assign hz.rf_raddr[1] = (opcode == OP_SW) ? instr_i.ri.rd : instr_i.rr.rs2;
  assign hz.rf_waddr    = instr_i.rr.rd;

  assign imm_ext = {{(`PIPE_XLEN-`PIPE_IMMW){instr_i.ri.imm[`PIPE_IMMW-1]}}, instr_i.ri.imm};

  regfile u_regfile (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (hz.rf_raddr[0]),
    .raddr_b_i (hz.rf_raddr[1]),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we_i),
    .waddr_i   (rf_waddr_i),
    .wdata_i   (rf_wdata_i)
  );

  assign op_a_fw = fw_mux(operand_a_sel_i, rdata_a, fw_ex_data_i, fw_wb_data_i);
  assign op_b_fw = fw_mux(operand_b_sel_i, rdata_b, fw_ex_data_i, fw_wb_data_i);

  // Intake opens the cycle after reset and closes on any stall
  assign instr_ready_o = ready_q && !stall_i;
  assign accept        = instr_valid_i && instr_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ready_q          <= 1'b0;
      id_ex_o.valid    <= 1'b0;
      id_ex_o.we       <= 1'b0;
      id_ex_o.data_req <= 1'b0;
    end
    else
    begin
      ready_q <= 1'b1;
      if (hz.wb_ready)                                 // Whole pipe holds on bus wait
      begin
        id_ex_o.valid      <= accept;                  // Not accepted means bubble
        id_ex_o.opcode     <= opcode;
        id_ex_o.rd         <= instr_i.rr.rd;
        id_ex_o.we         <= we_dec && !deassert_we_i;
        id_ex_o.data_req   <= data_req_dec && accept;
        id_ex_o.data_we    <= data_we_dec;
        id_ex_o.operand_a  <= op_a_fw;
        id_ex_o.operand_b  <= use_imm ? imm_ext : op_b_fw;
        id_ex_o.store_data <= op_b_fw;
      end
    end
  end

endmodule

// File: source/controller_bypass.sv
`timescale 1ns/1ps

module controller_bypass import pipe_pkg::*;
(
  hazard_if.ctrl     hz,
  input  logic       is_decoding_i,                   // Instruction transfers this cycle
  output op_fw_mux_e operand_a_sel_o,
  output op_fw_mux_e operand_b_sel_o,
  output logic       load_stall_o,
  output logic       wb_stall_o,
  output logic       deassert_we_o,
  output logic       halt_ex_o
);

  logic [1:0] rd_ex_match;                             // Read port hits EX destination
  logic [1:0] rd_wb_match;                             // Read port hits WB destination
  op_fw_mux_e fw_sel [2];

  ////////////////////////////////////////////////////////////////////////////
  // Address matching
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++)
  begin : gen_match
    // r0 and unread ports never match
    assign rd_ex_match[i] = hz.rf_we_ex && (hz.rf_waddr_ex == hz.rf_raddr[i]) &&
                            (|hz.rf_raddr[i]) && hz.rf_re[i];
    assign rd_wb_match[i] = hz.rf_we_wb && (hz.rf_waddr_wb == hz.rf_raddr[i]) &&
                            (|hz.rf_raddr[i]) && hz.rf_re[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////////////////////

  // Load in EX has no data yet, also load still waiting in WB
  assign load_stall_o = (hz.data_req_ex && |rd_ex_match) ||
                        (!hz.wb_ready && hz.data_req_wb && |rd_wb_match);

  assign wb_stall_o = !hz.wb_ready;
  assign halt_ex_o  = wb_stall_o;                      // EX only halts for the bus

  // Kill the write of a slot that is idle, stalled or targets r0
  assign deassert_we_o = !is_decoding_i || load_stall_o || wb_stall_o ||
                         (hz.rf_waddr == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Forward selects
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      fw_sel[i] = SEL_REGFILE;
      if (rd_wb_match[i])
        fw_sel[i] = SEL_FW_WB;                         // ALU result or load data in ack cycle
      if (rd_ex_match[i] && !hz.data_req_ex)
        fw_sel[i] = SEL_FW_EX;                         // Younger result wins
    end
  end

  assign operand_a_sel_o = fw_sel[0];
  assign operand_b_sel_o = fw_sel[1];

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module execute_stage import pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  id_ex_pipe_t           id_ex_i,
  input  logic                  halt_i,
  hazard_if.execute             hz,
  output logic [`PIPE_XLEN-1:0] result_o,            // EX forward value
  output ex_wb_pipe_t           ex_wb_o
);

  // ALU, memory ops reuse the adder for base plus offset
  always_comb
  begin
    case (id_ex_i.opcode)
      OP_ADD, OP_ADDI, OP_LW, OP_SW: result_o = id_ex_i.operand_a + id_ex_i.operand_b;
      OP_SUB:                        result_o = id_ex_i.operand_a - id_ex_i.operand_b;
      OP_AND:                        result_o = id_ex_i.operand_a & id_ex_i.operand_b;
      OP_OR:                         result_o = id_ex_i.operand_a | id_ex_i.operand_b;
      default:                       result_o = '0;
    endcase
  end

  // Destination published for hazard checks, load flag stops EX forwarding
  assign hz.rf_we_ex    = id_ex_i.valid && id_ex_i.we;
  assign hz.rf_waddr_ex = id_ex_i.rd;
  assign hz.data_req_ex = id_ex_i.valid && id_ex_i.data_req;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ex_wb_o.valid    <= 1'b0;
      ex_wb_o.we       <= 1'b0;
      ex_wb_o.data_req <= 1'b0;
    end
    else if (!halt_i)                                  // Held while WB waits on the bus
    begin
      ex_wb_o.valid      <= id_ex_i.valid;             // Decode bubbles pass through
      ex_wb_o.rd         <= id_ex_i.rd;
      ex_wb_o.we         <= id_ex_i.valid && id_ex_i.we;
      ex_wb_o.data_req   <= id_ex_i.valid && id_ex_i.data_req;
      ex_wb_o.data_we    <= id_ex_i.data_we;
      ex_wb_o.result     <= result_o;
      ex_wb_o.store_data <= id_ex_i.store_data;
    end
  end

endmodule

// File: source/writeback_lsu.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module writeback_lsu import pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  ex_wb_pipe_t           ex_wb_i,
  hazard_if.writeback           hz,
  // Wishbone classic master
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [`PIPE_XLEN-1:0] wb_adr_o,
  output logic [`PIPE_XLEN-1:0] wb_dat_o,
  input  logic [`PIPE_XLEN-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  // Register write port
  output logic                  rf_we_o,
  output rf_addr_t              rf_waddr_o,
  output logic [`PIPE_XLEN-1:0] rf_wdata_o,
  // Retire report
  output logic                  retire_valid_o,
  output rf_addr_t              retire_rd_o,
  output logic [`PIPE_XLEN-1:0] retire_data_o
);

  typedef enum logic {BUS_IDLE, BUS_BUSY} bus_state_e;

  bus_state_e state_q, state_d;
  logic       mem_op, bus_done;

  assign mem_op   = ex_wb_i.valid && ex_wb_i.data_req;
  assign bus_done = (state_q == BUS_BUSY) && wb_ack_i; // Ack sampled this cycle

  ////////////////////////////////////////////////////////////////////////////
  // Bus FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      BUS_IDLE: if (mem_op) state_d = BUS_BUSY;        // Open cycle for new access
      BUS_BUSY: if (wb_ack_i) state_d = BUS_IDLE;
      default:  state_d = BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      state_q <= BUS_IDLE;
    else
      state_q <= state_d;
  end

  assign wb_cyc_o = (state_q == BUS_BUSY);
  assign wb_stb_o = (state_q == BUS_BUSY);
  assign wb_we_o  = ex_wb_i.data_we;
  assign wb_adr_o = ex_wb_i.result;                    // Stable, EX/WB held until ack
  assign wb_dat_o = ex_wb_i.store_data;

  // Pipe may only advance once a memory op has its ack
  assign hz.wb_ready    = !mem_op || bus_done;
  assign hz.rf_we_wb    = ex_wb_i.valid && ex_wb_i.we;
  assign hz.rf_waddr_wb = ex_wb_i.rd;
  assign hz.data_req_wb = mem_op;

  // Loads write in the ack cycle, ALU ops right away
  assign rf_we_o    = hz.rf_we_wb && (!ex_wb_i.data_req || bus_done);
  assign rf_waddr_o = ex_wb_i.rd;
  assign rf_wdata_o = ex_wb_i.data_req ? wb_dat_i : ex_wb_i.result;

  assign retire_valid_o = rf_we_o;                     // r0 writes were dropped in decode
  assign retire_rd_o    = rf_waddr_o;
  assign retire_data_o  = rf_wdata_o;

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module core_top import pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  // Instruction stream
  input  logic                  instr_valid_i,
  input  logic [`PIPE_XLEN-1:0] instr_i,
  output logic                  instr_ready_o,
  // Wishbone data port
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [`PIPE_XLEN-1:0] wb_adr_o,
  output logic [`PIPE_XLEN-1:0] wb_dat_o,
  input  logic [`PIPE_XLEN-1:0] wb_dat_i,
  input  logic                  wb_ack_i,
  // Retire report
  output logic                  retire_valid_o,
  output logic [RF_AW-1:0]      retire_rd_o,
  output logic [`PIPE_XLEN-1:0] retire_data_o
);

  hazard_if              hz ();
  op_fw_mux_e            sel_a, sel_b;
  logic                  load_stall, wb_stall, deassert_we, halt_ex;
  id_ex_pipe_t           id_ex;
  ex_wb_pipe_t           ex_wb;
  logic [`PIPE_XLEN-1:0] ex_result, rf_wdata;
  logic                  rf_we;
  rf_addr_t              rf_waddr;

  decode_stage u_decode (
    .clk (clk), .rst_n_i (rst_n_i),
    .instr_valid_i (instr_valid_i), .instr_i (insn_u'(instr_i)),
    .instr_ready_o (instr_ready_o), .hz (hz.decode),
    .operand_a_sel_i (sel_a), .operand_b_sel_i (sel_b),
    .stall_i (load_stall || wb_stall), .deassert_we_i (deassert_we),
    .fw_ex_data_i (ex_result), .fw_wb_data_i (rf_wdata),
    .rf_we_i (rf_we), .rf_waddr_i (rf_waddr), .rf_wdata_i (rf_wdata),
    .id_ex_o (id_ex)
  );

  controller_bypass u_ctrl (
    .hz (hz.ctrl), .is_decoding_i (instr_valid_i && instr_ready_o),
    .operand_a_sel_o (sel_a), .operand_b_sel_o (sel_b),
    .load_stall_o (load_stall), .wb_stall_o (wb_stall),
    .deassert_we_o (deassert_we), .halt_ex_o (halt_ex)
  );

  execute_stage u_execute (
    .clk (clk), .rst_n_i (rst_n_i), .id_ex_i (id_ex), .halt_i (halt_ex),
    .hz (hz.execute), .result_o (ex_result), .ex_wb_o (ex_wb)
  );

  writeback_lsu u_writeback (
    .clk (clk), .rst_n_i (rst_n_i), .ex_wb_i (ex_wb), .hz (hz.writeback),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_we_o (wb_we_o),
    .wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_o), .wb_dat_i (wb_dat_i), .wb_ack_i (wb_ack_i),
    .rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata),
    .retire_valid_o (retire_valid_o), .retire_rd_o (retire_rd_o),
    .retire_data_o (retire_data_o)
  );

endmodule

// File: tests/core_assertions.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module core_assertions import pipe_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  instr_ready_o,
  input logic                  wb_cyc_o,
  input logic                  wb_stb_o,
  input logic                  wb_ack_i,
  input logic [`PIPE_XLEN-1:0] wb_adr_o,
  input logic [`PIPE_XLEN-1:0] wb_dat_o,
  input logic                  retire_valid_o,
  input logic [RF_AW-1:0]      retire_rd_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master rules
  ////////////////////////////////////////////////////////////////////////////

  stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i) wb_stb_o |-> wb_cyc_o)
    else $error("stb high without cyc");

  // Bus cycle ends the cycle after its ack
  cyc_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_cyc_o && wb_ack_i) |=> !wb_cyc_o)
    else $error("cyc still high after ack");

  // Open access keeps address and data until ack
  bus_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_stb_o && !wb_ack_i) |=> ($stable(wb_adr_o) && $stable(wb_dat_o)))
    else $error("bus address or data changed before ack");

  retire_no_r0: assert property (@(posedge clk) disable iff (!rst_n_i)
    retire_valid_o |-> (retire_rd_o != '0))
    else $error("retire reported for r0");

  // Flops are cleared from the second reset edge onward
  reset_idle: assert property (@(posedge clk)
    (!rst_n_i ##1 !rst_n_i) |-> (!instr_ready_o && !wb_cyc_o && !wb_stb_o && !retire_valid_o))
    else $error("outputs active during reset");

endmodule

// File: tests/core_tb.sv
`timescale 1ns/1ps
`include "pipe_defines.svh"

module core_tb;
  import pipe_pkg::*;

  localparam int NUM   = 24;                          // Table length
  localparam int LIMIT = 20 * NUM;                    // Cycle budget for the whole run

  typedef struct packed {
    opcode_e                op;
    logic [3:0]             rd;                       // Data register for SW
    logic [3:0]             rs1;
    logic [3:0]             rs2;
    logic [`PIPE_IMMW-1:0]  imm;
    logic [1:0]             gap;                      // Idle cycles before the instruction
    logic                   retires;                  // Expected to show on the retire port
  } step_t;

  typedef struct packed {
    logic [3:0]            rd;
    logic [`PIPE_XLEN-1:0] data;
  } retire_t;

  typedef struct packed {
    logic [`PIPE_XLEN-1:0] adr;
    logic [`PIPE_XLEN-1:0] data;
  } store_t;

  logic                  clk = 1'b0;
  logic                  rst_n_i;
  logic                  instr_valid_i, instr_ready_o;
  logic [`PIPE_XLEN-1:0] instr_i;
  logic                  wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
  logic [`PIPE_XLEN-1:0] wb_adr_o, wb_dat_o, wb_dat_i;
  logic                  retire_valid_o;
  logic [RF_AW-1:0]      retire_rd_o;
  logic [`PIPE_XLEN-1:0] retire_data_o;

  step_t                 prog [NUM];
  retire_t               exp_retire [$];
  store_t                exp_store [$];
  logic [`PIPE_XLEN-1:0] bus_mem [logic [`PIPE_XLEN-1:0]];   // Slave side memory
  int                    errors = 0;
  int                    cycles = 0;
  int                    retired = 0;
  int                    stored = 0;
  int unsigned           wait_left;
  logic                  pending;

  core_top UUT (.*);

  always #20 clk = ~clk;                              // 40 ns period

  // Unwritten memory reads back a pattern of its address
  function automatic logic [`PIPE_XLEN-1:0] mem_fill(input logic [`PIPE_XLEN-1:0] adr);
    return adr ^ {adr[15:0], 16'h5A5A} ^ 32'hC3000000;
  endfunction

  function automatic logic [`PIPE_XLEN-1:0] encode(input step_t s);
    if (s.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOP})
      return {s.op, s.rd, s.rs1, s.rs2, 16'h0000};
    return {s.op, s.rd, s.rs1, s.imm, 8'h00};
  endfunction

  task automatic put(input int i, input opcode_e op, input int rd, input int rs1,
                     input int rs2, input int imm, input int gap, input bit ret);
    prog[i] = {op, 4'(rd), 4'(rs1), 4'(rs2), 12'(imm), 2'(gap), ret};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    put( 0, OP_ADDI, 1, 0, 0,  5,    0, 1);
    put( 1, OP_ADDI, 2, 0, 0,  7,    0, 1);
    put( 2, OP_ADD,  3, 1, 2,  0,    0, 1);           // Distance 1 and 2
    put( 3, OP_SUB,  4, 3, 1,  0,    0, 1);
    put( 4, OP_OR,   5, 4, 3,  0,    1, 1);
    put( 5, OP_AND,  6, 5, 3,  0,    0, 1);
    put( 6, OP_ADDI, 0, 1, 0,  9,    0, 0);           // r0 target never retires
    put( 7, OP_ADD,  7, 0, 2,  0,    0, 1);           // Reads r0 right after
    put( 8, OP_ADDI, 8, 0, 0,  64,   2, 1);
    put( 9, OP_SW,   3, 8, 0,  0,    0, 0);
    put(10, OP_LW,   9, 8, 0,  0,    0, 1);
    put(11, OP_ADD, 10, 9, 1,  0,    0, 1);           // Load-use
    put(12, OP_LW,  11, 8, 0,  16,   0, 1);
    put(13, OP_SUB, 12, 11, 2, 0,    0, 1);
    put(14, OP_SW,  12, 8, 0,  4,    3, 0);
    put(15, OP_LW,  13, 8, 0,  4,    0, 1);
    put(16, OP_OR,  14, 13, 0, 0,    0, 1);
    put(17, OP_ADDI, 15, 14, 0, 'hFFF, 1, 1);
    put(18, OP_LW,   0, 8, 0,  0,    0, 0);
    put(19, OP_ADD,  1, 0, 0,  0,    0, 1);
    put(20, OP_SW,  15, 1, 0,  128,  0, 0);
    put(21, OP_LW,   2, 1, 0,  128,  0, 1);
    put(22, OP_AND,  3, 2, 15, 0,    0, 1);
    put(23, OP_NOP,  0, 0, 0,  0,    2, 0);
  endtask

  // Sequential reference that fills the expected retire and store queues
  task automatic run_model();
    logic [`PIPE_XLEN-1:0] regs [`PIPE_NREG];
    logic [`PIPE_XLEN-1:0] shadow [logic [`PIPE_XLEN-1:0]];
    logic [`PIPE_XLEN-1:0] a, b, imm, res;
    for (int r = 0; r < `PIPE_NREG; r++)
      regs[r] = '0;
    for (int i = 0; i < NUM; i++)
    begin
      a   = regs[prog[i].rs1];
      b   = regs[prog[i].rs2];
      imm = `PIPE_XLEN'($signed(prog[i].imm));
      res = '0;
      case (prog[i].op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_ADDI: res = a + imm;
        OP_LW:   res = shadow.exists(a + imm) ? shadow[a + imm] : mem_fill(a + imm);
        OP_SW:
        begin
          shadow[a + imm] = regs[prog[i].rd];
          exp_store.push_back({a + imm, regs[prog[i].rd]});
        end
        default: ;
      endcase
      if (prog[i].op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LW} && prog[i].rd != 0)
        regs[prog[i].rd] = res;
      if (prog[i].retires)
        exp_retire.push_back({prog[i].rd, res});
    end
  endtask

  task automatic check_idle(input string phase);
    if (instr_ready_o || wb_cyc_o || wb_stb_o || retire_valid_o)
    begin
      $display("ERR %0t: outputs not idle %s", $time, phase);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone slave with random wait states
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    store_t st;
    if (!rst_n_i || wb_ack_i)
    begin
      wb_ack_i = 1'b0;                                // Single cycle ack
      pending  = 1'b0;
    end
    else if (wb_cyc_o && wb_stb_o)
    begin
      if (!pending)
      begin
        pending   = 1'b1;
        wait_left = $urandom % 4;
      end
      if (wait_left == 0)
      begin
        wb_ack_i = 1'b1;
        if (wb_we_o)
        begin
          bus_mem[wb_adr_o] = wb_dat_o;
          stored++;
          if (exp_store.size() == 0)
          begin
            $display("ERR %0t: unexpected store adr %h data %h", $time, wb_adr_o, wb_dat_o);
            errors++;
          end
          else
          begin
            st = exp_store.pop_front();
            if (st.adr != wb_adr_o || st.data != wb_dat_o)
            begin
              $display("ERR %0t: store adr %h data %h, expected adr %h data %h",
                       $time, wb_adr_o, wb_dat_o, st.adr, st.data);
              errors++;
            end
          end
        end
        else
          wb_dat_i = bus_mem.exists(wb_adr_o) ? bus_mem[wb_adr_o] : mem_fill(wb_adr_o);
      end
      else
        wait_left--;
    end
  end

  // Retire port against the model queue
  always @(posedge clk)
  begin
    retire_t ex;
    if (rst_n_i && retire_valid_o)
    begin
      retired++;
      if (exp_retire.size() == 0)
      begin
        $display("ERR %0t: extra retire r%0d = %h", $time, retire_rd_o, retire_data_o);
        errors++;
      end
      else
      begin
        ex = exp_retire.pop_front();
        if (ex.rd != retire_rd_o || ex.data != retire_data_o)
        begin
          $display("ERR %0t: retire r%0d = %h, expected r%0d = %h",
                   $time, retire_rd_o, retire_data_o, ex.rd, ex.data);
          errors++;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("Timeout: pipeline did not drain within %0d cycles", LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(77485));
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    wb_ack_i      = 1'b0;
    wb_dat_i      = '0;
    pending       = 1'b0;
    wait_left     = 0;
    load_table();
    run_model();
    repeat (3)
    begin
      @(negedge clk);
      check_idle("during reset");
    end
    rst_n_i = 1'b1;
    for (int i = 0; i < NUM; i++)
    begin
      instr_valid_i = 1'b0;
      repeat (prog[i].gap) @(negedge clk);
      instr_valid_i = 1'b1;
      instr_i       = encode(prog[i]);
      @(posedge clk);
      while (!instr_ready_o) @(posedge clk);          // Held until transfer
      @(negedge clk);
      if (i == 0 && (wb_cyc_o || wb_stb_o))
      begin
        $display("ERR %0t: bus active right after reset", $time);
        errors++;
      end
    end
    instr_valid_i = 1'b0;
    while (exp_retire.size() != 0 || exp_store.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("Run done: %0d errors, %0d retires, %0d stores", errors, retired, stored);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

bind core_top core_assertions u_assertions (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .instr_ready_o  (instr_ready_o),
  .wb_cyc_o       (wb_cyc_o),
  .wb_stb_o       (wb_stb_o),
  .wb_ack_i       (wb_ack_i),
  .wb_adr_o       (wb_adr_o),
  .wb_dat_o       (wb_dat_o),
  .retire_valid_o (retire_valid_o),
  .retire_rd_o    (retire_rd_o)
);

// File: tb.f
+incdir+source
source/pipe_pkg.sv
source/hazard_if.sv
source/regfile.sv
source/decode_stage.sv
source/controller_bypass.sv
source/execute_stage.sv
source/writeback_lsu.sv
source/core_top.sv
tests/core_assertions.sv
tests/core_tb.sv

// File: Makefile
TOP = core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
